/* all.f */
+incdir+include
verilog/bj_pkg.sv
verilog/bj_button_front.sv
verilog/bj_card_source.sv
verilog/bj_play_ctrl.sv
verilog/bj_outcome.sv
verilog/bj_top.sv
dv/bj_tb.sv

/* include/bj_tb_tasks.svh */
// ##########################################################
// Blackjack testbench tasks, directed games and their checks
// ##########################################################
`ifndef BJ_TB_TASKS_SVH
`define BJ_TB_TASKS_SVH

task automatic report_value(input string name, input logic [31:0] exp_val,
                            input logic [31:0] got_val);
    $display("[ERROR] %s expected %h got %h", name, exp_val, got_val);
    err_count++;
endtask

task automatic report_fail(input string msg);
    $display("Failure: %s", msg);
    err_count++;
endtask

task automatic finish_test(input string name, input int errs_before);
    tests_run++;
    if (err_count != errs_before) begin
        tests_failed++;
        $display("%s: failed with %0d errors", name, err_count - errs_before);
    end else begin
        $display("%s: passed", name);
    end
endtask

// Hold a button low for 1 to 4 cycles, then release it
task automatic press_button(input int which);
    int hold;
    hold = 1 + int'(take_bits(2));
    @(posedge clk);
    case (which)
        BTN_BEGIN: begin_n <= 1'b0;
        BTN_HIT:   hit_n   <= 1'b0;
        default:   stand_n <= 1'b0;
    endcase
    repeat (hold) @(posedge clk);
    begin_n <= 1'b1;
    hit_n   <= 1'b1;
    stand_n <= 1'b1;
endtask

task automatic wait_cards(input int n);
    while (card_vals.size() < n) begin
        @(negedge clk);
    end
endtask

task automatic wait_results(input int n);
    while (results.size() < n) begin
        @(negedge clk);
    end
endtask

// Player bust first, then house bust, then the higher sum
function automatic bj_outcome_e judge(input int psum, input int hsum, input logic bust);
    if (bust) begin
        return HOUSE_WIN;
    end
    if (hsum > BLACKJACK) begin
        return PLAYER_WIN;
    end
    if (psum > hsum) begin
        return PLAYER_WIN;
    end
    if (psum < hsum) begin
        return HOUSE_WIN;
    end
    return DRAW;
endfunction

// Sum of the recorded player cards from one game start onward
function automatic int player_total(input int first);
    int total;
    int idx;
    total = 0;
    for (idx = first; idx < card_vals.size(); idx++) begin
        if (!card_house[idx]) begin
            total += card_vals[idx];
        end
    end
    return total;
endfunction

// One full game, hits up to max_hits while below 21, then stands
task automatic play_game(input logic [SEED_W-1:0] game_seed, input int max_hits,
                         input logic hit_in_deal, output int first);
    int          nres;
    int          psum;
    int          hsum;
    int          hits;
    int          idx;
    logic        bust;
    bj_outcome_e exp_out;
    bj_result_t  res;

    first = card_vals.size();
    nres  = results.size();
    @(posedge clk);
    seed <= game_seed;
    press_button(BTN_BEGIN);
    // This hit pulse lands while the deal is still running
    if (hit_in_deal) begin
        press_button(BTN_HIT);
    end
    wait_cards(first + DEAL_CARDS);
    while (phase != PLAYING) begin
        @(negedge clk);
    end
    // Deal order is player, house, player, house
    for (idx = first; idx < first + DEAL_CARDS; idx++) begin
        if (card_house[idx] != ((idx - first) % 2 == 1)) begin
            report_value("card_event.to_house", (idx - first) % 2, card_house[idx]);
        end
    end
    if (hit_in_deal) begin
        repeat (12) @(negedge clk);
        if (card_vals.size() != first + DEAL_CARDS) begin
            report_fail("a hit during the deal drew an extra card");
        end
    end
    psum = card_vals[first] + card_vals[first + 2];
    hsum = card_vals[first + 1] + card_vals[first + 3];

    hits = 0;
    while (psum < BLACKJACK && hits < max_hits) begin
        press_button(BTN_HIT);
        wait_cards(first + DEAL_CARDS + hits + 1);
        idx = first + DEAL_CARDS + hits;
        if (card_house[idx]) begin
            report_value("card_event.to_house", 0, card_house[idx]);
        end
        psum += card_vals[idx];
        hits++;
    end
    bust = (psum > BLACKJACK);
    // At exactly 21 the house turn starts by itself
    if (psum < BLACKJACK) begin
        press_button(BTN_STAND);
    end
    wait_results(nres + 1);
    res = results[nres];

    for (idx = first; idx < card_vals.size(); idx++) begin
        if (card_vals[idx] < 1 || card_vals[idx] > CARD_MAX) begin
            report_fail($sformatf("card value %0d outside 1 to 10", card_vals[idx]));
        end
    end
    // Replay the house turn on the recorded cards
    for (idx = first + DEAL_CARDS + hits; idx < card_vals.size(); idx++) begin
        if (!card_house[idx]) begin
            report_fail("player card drawn without a hit");
        end else if (bust) begin
            report_fail("house drew a card after a player bust");
        end else begin
            if (hsum >= HOUSE_STAND) begin
                report_fail($sformatf("house drew at sum %0d", hsum));
            end
            hsum += card_vals[idx];
        end
    end
    if (!bust && hsum < HOUSE_STAND) begin
        report_fail($sformatf("house stopped drawing at sum %0d", hsum));
    end

    exp_out = judge(psum, hsum, bust);
    if (res.outcome != exp_out) begin
        report_value("result.outcome", exp_out, res.outcome);
    end
    if (res.player_sum != psum) begin
        report_value("result.player_sum", psum, res.player_sum);
    end
    if (res.house_sum != hsum) begin
        report_value("result.house_sum", hsum, res.house_sum);
    end
    case (exp_out)
        PLAYER_WIN: exp_player_wins++;
        HOUSE_WIN:  exp_house_wins++;
        default:    exp_draws++;
    endcase
    if (player_wins != exp_player_wins) begin
        report_value("player_wins", exp_player_wins, player_wins);
    end
    if (house_wins != exp_house_wins) begin
        report_value("house_wins", exp_house_wins, house_wins);
    end
    if (draws != exp_draws) begin
        report_value("draws", exp_draws, draws);
    end
endtask

task automatic test_reset();
    int errs;
    errs = err_count;
    @(negedge clk);
    if (card_event.valid !== 1'b0) begin
        report_value("card_event.valid", 0, card_event.valid);
    end
    if (result.valid !== 1'b0) begin
        report_value("result.valid", 0, result.valid);
    end
    if (player_wins !== '0) begin
        report_value("player_wins", 0, player_wins);
    end
    if (house_wins !== '0) begin
        report_value("house_wins", 0, house_wins);
    end
    if (draws !== '0) begin
        report_value("draws", 0, draws);
    end
    if (phase !== DEAL_ROUND_1) begin
        report_value("phase", DEAL_ROUND_1, phase);
    end
    finish_test("reset", errs);
endtask

task automatic test_deal_and_stand();
    int errs;
    int first;
    errs = err_count;
    play_game(SEED_W'(take_bits(SEED_W)), 0, 1'b0, first);
    play_game(SEED_W'(take_bits(SEED_W)), 1, 1'b0, first);
    finish_test("deal and stand", errs);
endtask

task automatic test_player_bust();
    int   errs;
    int   first;
    int   tries;
    logic busted;
    errs   = err_count;
    busted = 1'b0;
    // Exactly 21 ends the player turn without a bust, so fresh seeds follow
    for (tries = 0; tries < 4 && !busted; tries++) begin
        play_game(SEED_W'(take_bits(SEED_W)), 10, 1'b0, first);
        busted = (player_total(first) > BLACKJACK);
    end
    if (!busted) begin
        report_fail("no game ended in a player bust");
    end
    finish_test("player bust", errs);
endtask

task automatic test_seed_repeat();
    int                errs;
    int                first_a;
    int                first_b;
    int                first_c;
    int                len_a;
    int                len_b;
    int                len_c;
    int                idx;
    logic [31:0]       rnd;
    logic [SEED_W-1:0] seed_a;
    logic              same;
    errs = err_count;
    // Seeds differ in the low nibble, so the first rank differs
    rnd    = take_bits(12);
    seed_a = {rnd[11:0], 4'h3};
    play_game(seed_a, 1, 1'b0, first_a);
    play_game(seed_a, 1, 1'b0, first_b);
    play_game(seed_a ^ 16'h0004, 1, 1'b0, first_c);
    len_a = first_b - first_a;
    len_b = first_c - first_b;
    len_c = card_vals.size() - first_c;
    if (len_a != len_b) begin
        report_fail("same seed gave a different number of cards");
    end else begin
        for (idx = 0; idx < len_a; idx++) begin
            if (card_vals[first_b + idx] != card_vals[first_a + idx]) begin
                report_value("card_event.value", card_vals[first_a + idx],
                             card_vals[first_b + idx]);
            end
        end
    end
    same = (len_a == len_c);
    for (idx = 0; idx < len_a && idx < len_c; idx++) begin
        if (card_vals[first_c + idx] != card_vals[first_a + idx]) begin
            same = 1'b0;
        end
    end
    if (same) begin
        report_fail("a different seed gave the same card sequence");
    end
    finish_test("seed repeat", errs);
endtask

// Tallies are checked after every game, odd games press hit during the deal
task automatic test_tally();
    int errs;
    int game;
    int first;
    int hits;
    errs = err_count;
    for (game = 0; game < 6; game++) begin
        hits = int'(take_bits(2)) % 3;
        play_game(SEED_W'(take_bits(SEED_W)), hits, game[0], first);
    end
    finish_test("tally", errs);
endtask

`endif

/* dv/bj_tb.sv */
// ##########################################################
// Blackjack engine testbench
// Directed games against the full engine, closing summary
// ##########################################################
`timescale 1ns/1ns

module bj_tb;
    import bj_pkg::*;

    // Roughly 150 cycles per game and 12 games, four times over with margin
    localparam int MAX_CYCLES = 20000;
    localparam int DEAL_CARDS = 4;
    // Button selectors for the press task
    localparam int BTN_BEGIN  = 0;
    localparam int BTN_HIT    = 1;
    localparam int BTN_STAND  = 2;

    logic               clk;
    logic               rst;
    logic               begin_n;
    logic               hit_n;
    logic               stand_n;
    logic [SEED_W-1:0]  seed;
    bj_card_event_t     card_event;
    bj_phase_e          phase;
    bj_result_t         result;
    logic [TALLY_W-1:0] player_wins;
    logic [TALLY_W-1:0] house_wins;
    logic [TALLY_W-1:0] draws;

    // Every dealt card and every judged result, in arrival order
    logic [CARD_W-1:0]  card_vals[$];
    logic               card_house[$];
    bj_result_t         results[$];

    logic [31:0]        rng_state;
    int                 cycle_count;
    int                 err_count;
    int                 tests_run;
    int                 tests_failed;
    // Tallies predicted from the recorded games
    int                 exp_player_wins;
    int                 exp_house_wins;
    int                 exp_draws;

    bj_top dut0 (
        .clk         (clk),
        .rst         (rst),
        .begin_n     (begin_n),
        .hit_n       (hit_n),
        .stand_n     (stand_n),
        .seed        (seed),
        .card_event  (card_event),
        .phase       (phase),
        .result      (result),
        .player_wins (player_wins),
        .house_wins  (house_wins),
        .draws       (draws)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Watchdog on the cycle count
    initial begin
        cycle_count = 0;
        while (cycle_count < MAX_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout, run stopped after %0d cycles", cycle_count);
        $display("Done: errors found");
        $finish;
    end

    // Outputs are registered, so the falling edge sees them settled
    always @(negedge clk) begin
        if (card_event.valid) begin
            card_vals.push_back(card_event.value);
            card_house.push_back(card_event.to_house);
        end
        if (result.valid) begin
            results.push_back(result);
        end
    end

    // Fibonacci LFSR with taps 32, 22, 2 and 1, one step per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] bits;
        logic        fb;
        int          i;
        bits = '0;
        for (i = 0; i < n; i++) begin
            fb        = rng_state[31] ^ rng_state[21] ^ rng_state[1] ^ rng_state[0];
            rng_state = {rng_state[30:0], fb};
            bits      = {bits[30:0], fb};
        end
        return bits;
    endfunction

    `include "bj_tb_tasks.svh"

    initial begin
        rng_state       = 32'h958f9439;
        err_count       = 0;
        tests_run       = 0;
        tests_failed    = 0;
        exp_player_wins = 0;
        exp_house_wins  = 0;
        exp_draws       = 0;
        rst             = 1'b0;
        begin_n         = 1'b1;
        hit_n           = 1'b1;
        stand_n         = 1'b1;
        seed            = '0;
        repeat (5) @(posedge clk);
        rst <= 1'b1;

        test_reset();
        test_deal_and_stand();
        test_player_bust();
        test_seed_repeat();
        test_tally();

        $display("Summary: %0d tests, %0d failed, %0d errors",
                 tests_run, tests_failed, err_count);
        if (err_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* verilog/bj_button_front.sv */
// ##########################################################
// Button front end, one pulse per button release
// ##########################################################
`timescale 1ns/1ns

module bj_button_front (
    input  logic            clk,
    input  logic            rst,
    input  logic            begin_n,
    input  logic            hit_n,
    input  logic            stand_n,
    output bj_pkg::bj_cmd_t cmd
);

    // Bit order matches the cmd struct, begin on top
    logic [2:0] pin_n;
    logic [2:0] sync1_n;
    logic [2:0] sync2_n;
    logic [2:0] prev_n;
    logic [2:0] release_det;
    logic [2:0] pulse_q;

    assign pin_n = {begin_n, hit_n, stand_n};

    // Release is a low to high step of the synchronized level
    assign release_det = sync2_n & ~prev_n;

    // Idle buttons read high, so everything resets to released
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            sync1_n <= 3'b111;
            sync2_n <= 3'b111;
            prev_n  <= 3'b111;
        end else begin
            // Two flops against metastability
            sync1_n <= pin_n;
            sync2_n <= sync1_n;
            // Previous level for the edge detect
            prev_n  <= sync2_n;
        end
    end

    // Registered pulse, three cycles after the pin rises
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            pulse_q <= 3'b000;
        end else begin
            pulse_q <= release_det;
        end
    end

    assign cmd = '{begin_game: pulse_q[2], hit: pulse_q[1], stand: pulse_q[0]};

endmodule

/* verilog/bj_card_source.sv */
// ##########################################################
// Card source, seeded LFSR giving one card value per request
// ##########################################################
`timescale 1ns/1ns

module bj_card_source (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      shuffle,
    input  logic                      card_req,
    input  logic [bj_pkg::SEED_W-1:0] seed,
    output bj_pkg::bj_card_t          card
);
    import bj_pkg::*;

    logic [SEED_W-1:0] lfsr;
    logic              feedback;
    logic [SEED_W-1:0] seed_safe;
    logic [CARD_W-1:0] rank;
    logic [CARD_W-1:0] folded;
    logic              take;
    logic              ack_q;
    logic [CARD_W-1:0] value_q;

    // Taps 16, 14, 13 and 11
    assign feedback = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];

    // All-zero state would lock the register
    assign seed_safe = (seed == '0) ? SEED_W'(1) : seed;

    // New request seen while no ack is out
    assign take = card_req && !ack_q;

    // Rank from the low bits, folded into 1 to 10
    assign rank = lfsr[CARD_W-1:0];

    always_comb begin
        if (rank == '0) begin
            folded = CARD_W'(1);
        end else if (rank > CARD_MAX) begin
            // Ranks 11 to 15 all count as ten
            folded = CARD_MAX;
        end else begin
            folded = rank;
        end
    end

    // LFSR and ack pulse
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            lfsr  <= SEED_W'(1);
            ack_q <= 1'b0;
        end else begin
            ack_q <= take;
            if (shuffle) begin
                lfsr <= seed_safe;
            end else if (take) begin
                // Advance on the same edge that raises ack
                lfsr <= {lfsr[SEED_W-2:0], feedback};
            end
        end
    end

    // Card value captured with the ack
    always_ff @(posedge clk) begin
        if (take) begin
            value_q <= folded;
        end
    end

    assign card = '{ack: ack_q, value: value_q};

endmodule

/* verilog/bj_outcome.sv */
// ##########################################################
// Outcome judge with win, loss and draw tally
// ##########################################################
`timescale 1ns/1ns

module bj_outcome (
    input  logic                       clk,
    input  logic                       rst,
    input  bj_pkg::bj_hand_t           hand,
    output bj_pkg::bj_result_t         result,
    output logic [bj_pkg::TALLY_W-1:0] player_wins,
    output logic [bj_pkg::TALLY_W-1:0] house_wins,
    output logic [bj_pkg::TALLY_W-1:0] draws
);
    import bj_pkg::*;

    bj_outcome_e verdict;

    // Player bust first, then house bust, then the higher sum
    always_comb begin
        if (hand.player_bust) begin
            verdict = HOUSE_WIN;
        end else if (hand.house_sum > BLACKJACK) begin
            verdict = PLAYER_WIN;
        end else if (hand.player_sum > hand.house_sum) begin
            verdict = PLAYER_WIN;
        end else if (hand.player_sum < hand.house_sum) begin
            verdict = HOUSE_WIN;
        end else begin
            verdict = DRAW;
        end
    end

    // Result flag, outcome, final sums and the saturating tallies
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            result.valid      <= 1'b0;
            result.outcome    <= NONE;
            result.player_sum <= '0;
            result.house_sum  <= '0;
            player_wins       <= '0;
            house_wins        <= '0;
            draws             <= '0;
        end else begin
            result.valid <= hand.done;
            if (hand.done) begin
                result.outcome    <= verdict;
                // Final sums travel with the result
                result.player_sum <= hand.player_sum;
                result.house_sum  <= hand.house_sum;
                case (verdict)
                    PLAYER_WIN: begin
                        if (player_wins != '1) begin
                            player_wins <= player_wins + 1'b1;
                        end
                    end
                    HOUSE_WIN: begin
                        if (house_wins != '1) begin
                            house_wins <= house_wins + 1'b1;
                        end
                    end
                    DRAW: begin
                        if (draws != '1) begin
                            draws <= draws + 1'b1;
                        end
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

endmodule

/* verilog/bj_pkg.sv */
// ##########################################################
// Blackjack engine shared constants, enums and structs
// ##########################################################
package bj_pkg;

    // Data widths
    localparam int CARD_W  = 4;
    localparam int SUM_W   = 6;
    localparam int SEED_W  = 16;
    localparam int TALLY_W = 8;

    // Game limits
    localparam logic [SUM_W-1:0]  BLACKJACK   = 6'd21;
    localparam logic [SUM_W-1:0]  HOUSE_STAND = 6'd17;
    // Face cards and ranks above ten all count as ten
    localparam logic [CARD_W-1:0] CARD_MAX    = 4'd10;

    // Game phase, follows the deal rounds into play
    typedef enum logic [1:0] {
        DEAL_ROUND_1 = 2'b00,
        DEAL_ROUND_2 = 2'b01,
        PLAYING      = 2'b10,
        PLAY_DONE    = 2'b11
    } bj_phase_e;

    // Result of one hand
    typedef enum logic [1:0] {
        NONE       = 2'b00,
        PLAYER_WIN = 2'b01,
        HOUSE_WIN  = 2'b10,
        DRAW       = 2'b11
    } bj_outcome_e;

    // One-cycle button release pulses
    typedef struct packed {
        logic begin_game;
        logic hit;
        logic stand;
    } bj_cmd_t;

    // Card returned by the card source, value valid with ack
    typedef struct packed {
        logic              ack;
        logic [CARD_W-1:0] value;
    } bj_card_t;

    // Dealt card as reported at the top level
    typedef struct packed {
        logic              valid;
        logic              to_house;
        logic [CARD_W-1:0] value;
    } bj_card_event_t;

    // Finished hand handed to the judge
    typedef struct packed {
        logic             done;
        logic             player_bust;
        logic [SUM_W-1:0] player_sum;
        logic [SUM_W-1:0] house_sum;
    } bj_hand_t;

    // Judged result with the final sums
    typedef struct packed {
        logic             valid;
        bj_outcome_e      outcome;
        logic [SUM_W-1:0] player_sum;
        logic [SUM_W-1:0] house_sum;
    } bj_result_t;

endpackage

/* verilog/bj_play_ctrl.sv */
// ##########################################################
// Play controller, deals the hand and runs both turns
// Keeps the two sums and hands over each finished hand
// ##########################################################
`timescale 1ns/1ns

module bj_play_ctrl (
    input  logic                   clk,
    input  logic                   rst,
    input  bj_pkg::bj_cmd_t        cmd,
    input  bj_pkg::bj_card_t       card,
    output logic                   card_req,
    output logic                   shuffle,
    output bj_pkg::bj_card_event_t card_event,
    output bj_pkg::bj_phase_e      phase,
    output bj_pkg::bj_hand_t       hand
);
    import bj_pkg::*;

    // Controller states, phase tells which part of the game they serve
    typedef enum logic [2:0] {
        S_IDLE    = 3'd0,
        S_SHUFFLE = 3'd1,
        S_DRAW    = 3'd2,
        S_SCORE   = 3'd3,
        S_PLAYER  = 3'd4,
        S_HOUSE   = 3'd5
    } ctrl_state_e;

    ctrl_state_e      state;
    // Who receives the card being drawn
    logic             to_house;
    logic [SUM_W-1:0] player_sum;
    logic [SUM_W-1:0] house_sum;
    logic             done_q;
    logic             bust_q;
    logic [SUM_W-1:0] card_ext;

    assign card_ext = SUM_W'(card.value);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state      <= S_IDLE;
            phase      <= DEAL_ROUND_1;
            to_house   <= 1'b0;
            player_sum <= '0;
            house_sum  <= '0;
            card_req   <= 1'b0;
            shuffle    <= 1'b0;
            card_event <= '0;
            done_q     <= 1'b0;
            bust_q     <= 1'b0;
        end else begin
            // Pulses last one cycle
            shuffle          <= 1'b0;
            card_event.valid <= 1'b0;
            done_q           <= 1'b0;

            case (state)
                S_IDLE: begin
                    // New game on begin release
                    if (cmd.begin_game) begin
                        shuffle    <= 1'b1;
                        phase      <= DEAL_ROUND_1;
                        player_sum <= '0;
                        house_sum  <= '0;
                        bust_q     <= 1'b0;
                        state      <= S_SHUFFLE;
                    end
                end

                S_SHUFFLE: begin
                    // Seed loads this cycle, first deal goes to the player
                    to_house <= 1'b0;
                    card_req <= 1'b1;
                    state    <= S_DRAW;
                end

                S_DRAW: begin
                    // Request held until the card source answers
                    if (card.ack) begin
                        card_req            <= 1'b0;
                        card_event.valid    <= 1'b1;
                        card_event.to_house <= to_house;
                        card_event.value    <= card.value;
                        if (to_house) begin
                            house_sum <= house_sum + card_ext;
                        end else begin
                            player_sum <= player_sum + card_ext;
                        end
                        state <= S_SCORE;
                    end
                end

                S_SCORE: begin
                    // Sums now include the card just drawn
                    case (phase)
                        DEAL_ROUND_1: begin
                            if (!to_house) begin
                                to_house <= 1'b1;
                            end else begin
                                to_house <= 1'b0;
                                phase    <= DEAL_ROUND_2;
                            end
                            card_req <= 1'b1;
                            state    <= S_DRAW;
                        end
                        DEAL_ROUND_2: begin
                            if (!to_house) begin
                                // Second house card closes the deal
                                to_house <= 1'b1;
                                card_req <= 1'b1;
                                state    <= S_DRAW;
                            end else begin
                                phase <= PLAYING;
                                state <= S_PLAYER;
                            end
                        end
                        PLAYING: begin
                            if (player_sum > BLACKJACK) begin
                                // Player bust ends the hand at once
                                phase  <= PLAY_DONE;
                                bust_q <= 1'b1;
                                done_q <= 1'b1;
                                state  <= S_IDLE;
                            end else if (player_sum == BLACKJACK) begin
                                phase <= PLAY_DONE;
                                state <= S_HOUSE;
                            end else begin
                                state <= S_PLAYER;
                            end
                        end
                        default: begin
                            // House card during its own turn
                            state <= S_HOUSE;
                        end
                    endcase
                end

                S_PLAYER: begin
                    // Hit wins over a stand in the same cycle
                    if (cmd.hit) begin
                        to_house <= 1'b0;
                        card_req <= 1'b1;
                        state    <= S_DRAW;
                    end else if (cmd.stand) begin
                        phase <= PLAY_DONE;
                        state <= S_HOUSE;
                    end
                end

                S_HOUSE: begin
                    // House draws below its stand limit
                    if (house_sum < HOUSE_STAND) begin
                        to_house <= 1'b1;
                        card_req <= 1'b1;
                        state    <= S_DRAW;
                    end else begin
                        done_q <= 1'b1;
                        state  <= S_IDLE;
                    end
                end

                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    // Sums stay stable while done pulses
    assign hand = '{
        done:        done_q,
        player_bust: bust_q,
        player_sum:  player_sum,
        house_sum:   house_sum
    };

endmodule

/* verilog/bj_top.sv */
// ##########################################################
// Blackjack engine top level
// Buttons, card source, play controller and outcome judge
// ##########################################################
`timescale 1ns/1ns

module bj_top (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       begin_n,
    input  logic                       hit_n,
    input  logic                       stand_n,
    input  logic [bj_pkg::SEED_W-1:0]  seed,
    output bj_pkg::bj_card_event_t     card_event,
    output bj_pkg::bj_phase_e          phase,
    output bj_pkg::bj_result_t         result,
    output logic [bj_pkg::TALLY_W-1:0] player_wins,
    output logic [bj_pkg::TALLY_W-1:0] house_wins,
    output logic [bj_pkg::TALLY_W-1:0] draws
);
    import bj_pkg::*;

    // Release pulses from the front end
    bj_cmd_t  cmd;
    // Card handshake
    bj_card_t card;
    logic     card_req;
    logic     shuffle;
    // Finished hand to the judge
    bj_hand_t hand;

    bj_button_front u_button_front (
        .clk     (clk),
        .rst     (rst),
        .begin_n (begin_n),
        .hit_n   (hit_n),
        .stand_n (stand_n),
        .cmd     (cmd)
    );

    bj_card_source u_card_source (
        .clk      (clk),
        .rst      (rst),
        .shuffle  (shuffle),
        .card_req (card_req),
        .seed     (seed),
        .card     (card)
    );

    bj_play_ctrl u_play_ctrl (
        .clk        (clk),
        .rst        (rst),
        .cmd        (cmd),
        .card       (card),
        .card_req   (card_req),
        .shuffle    (shuffle),
        .card_event (card_event),
        .phase      (phase),
        .hand       (hand)
    );

    bj_outcome u_outcome (
        .clk         (clk),
        .rst         (rst),
        .hand        (hand),
        .result      (result),
        .player_wins (player_wins),
        .house_wins  (house_wins),
        .draws       (draws)
    );

endmodule
